//--- rtl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// first instruction address
`define PC_INIT 32'h0000_0000

// instruction tag counter width
`define TAG_W 8

`endif

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JAL  = 2'd3
    } br_kind_e;

    typedef enum logic [1:0] {
        FS_ISSUE = 2'd0,
        FS_WAIT  = 2'd1,
        FS_STALL = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

//--- rtl/fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module fetch (
    input  logic                clk,
    input  logic                rst,
    output logic                ireq_valid,
    output logic [`XLEN-1:0]    ireq_addr,
    input  logic                iresp_data_ok,
    input  logic [`XLEN-1:0]    iresp_data,
    input  logic                jump_valid,
    input  logic                jump_taken,
    input  logic [`XLEN-1:0]    jump_target,
    input  logic [`TAG_W-1:0]   jump_tag,
    output logic                fd_valid,
    output logic [`XLEN-1:0]    fd_inst,
    output logic [`XLEN-1:0]    fd_pc,
    output logic [`TAG_W-1:0]   fd_tag
);
    import core_pkg::*;

    fetch_state_e       state;
    logic [`XLEN-1:0]   pc;
    logic [`TAG_W-1:0]  tag_cnt;
    logic [`TAG_W-1:0]  stall_tag;
    opcode_e            resp_op;
    logic               resp_is_cf;
    logic               issue_now;
    logic               take_resp;
    logic               jump_release;
    logic [`XLEN-1:0]   next_pc;

    assign resp_op    = opcode_e'(iresp_data[6:0]);
    assign resp_is_cf = (resp_op == BRANCH) || (resp_op == JAL);

    assign issue_now    = (state == FS_ISSUE);
    assign take_resp    = (state == FS_WAIT) && iresp_data_ok;
    // only the report for the instruction we stalled on wakes us up
    assign jump_release = (state == FS_STALL) && jump_valid && (jump_tag == stall_tag);
    assign next_pc      = jump_taken ? jump_target : pc + 4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FS_ISSUE;
            pc         <= `PC_INIT;
            tag_cnt    <= '0;
            ireq_valid <= 1'b0;
            fd_valid   <= 1'b0;
        end else begin
            fd_valid <= take_resp;
            if (issue_now) begin
                ireq_valid <= 1'b1;
                state      <= FS_WAIT;
            end else if (take_resp) begin
                ireq_valid <= 1'b0;
                tag_cnt    <= tag_cnt + 1'b1;
                if (resp_is_cf) begin
                    state <= FS_STALL;
                end else begin
                    pc    <= pc + 4;
                    state <= FS_ISSUE;
                end
            end else if (jump_release) begin
                // redirect straight onto the bus
                pc         <= next_pc;
                ireq_valid <= 1'b1;
                state      <= FS_WAIT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_now) begin
            ireq_addr <= pc;
        end else if (jump_release) begin
            ireq_addr <= next_pc;
        end
        if (take_resp) begin
            fd_inst <= iresp_data;
            fd_pc   <= pc;
            fd_tag  <= tag_cnt;
            if (resp_is_cf) begin
                stall_tag <= tag_cnt;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                fd_valid,
    input  logic [`XLEN-1:0]    fd_inst,
    input  logic [`XLEN-1:0]    fd_pc,
    input  logic [`TAG_W-1:0]   fd_tag,
    output logic                de_valid,
    output core_pkg::alu_op_e   de_alu_op,
    output core_pkg::br_kind_e  de_br_kind,
    output logic [4:0]          de_rd,
    output logic [4:0]          de_rs1,
    output logic [4:0]          de_rs2,
    output logic [`XLEN-1:0]    de_imm,
    output logic                de_use_imm,
    output logic [`XLEN-1:0]    de_pc,
    output logic [`TAG_W-1:0]   de_tag
);
    import core_pkg::*;

    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_j;
    alu_op_e            alu_op;
    br_kind_e           br_kind;
    logic [4:0]         rd;
    logic [`XLEN-1:0]   imm;
    logic               use_imm;

    assign funct3 = fd_inst[14:12];
    assign funct7 = fd_inst[31:25];

    assign imm_i = {{(`XLEN-12){fd_inst[31]}}, fd_inst[31:20]};
    assign imm_u = {fd_inst[31:12], 12'b0};
    assign imm_b = {{(`XLEN-12){fd_inst[31]}}, fd_inst[7], fd_inst[30:25],
                    fd_inst[11:8], 1'b0};
    assign imm_j = {{(`XLEN-20){fd_inst[31]}}, fd_inst[19:12], fd_inst[20],
                    fd_inst[30:21], 1'b0};

    always_comb begin
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        rd      = fd_inst[11:7];
        imm     = imm_i;
        use_imm = 1'b1;
        case (opcode_e'(fd_inst[6:0]))
            OP_IMM: begin
                // ADDI only
                if (funct3 != 3'b000) begin
                    rd = 5'd0;
                end
            end
            OP: begin
                use_imm = 1'b0;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: alu_op = ALU_AND;
                    default:              rd = 5'd0;
                endcase
            end
            LUI: begin
                alu_op = ALU_PASS_B;
                imm    = imm_u;
            end
            BRANCH: begin
                // fetch is stalled on every branch, so each one must resolve
                br_kind = fd_inst[12] ? BR_NE : BR_EQ;
                rd      = 5'd0;
                imm     = imm_b;
                use_imm = 1'b0;
            end
            JAL: begin
                br_kind = BR_JAL;
                imm     = imm_j;
            end
            default: rd = 5'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fd_valid) begin
            de_alu_op  <= alu_op;
            de_br_kind <= br_kind;
            de_rd      <= rd;
            de_rs1     <= fd_inst[19:15];
            de_rs2     <= fd_inst[24:20];
            de_imm     <= imm;
            de_use_imm <= use_imm;
            de_pc      <= fd_pc;
            de_tag     <= fd_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                de_valid,
    input  core_pkg::alu_op_e   de_alu_op,
    input  core_pkg::br_kind_e  de_br_kind,
    input  logic [4:0]          de_rd,
    input  logic [4:0]          de_rs1,
    input  logic [4:0]          de_rs2,
    input  logic [`XLEN-1:0]    de_imm,
    input  logic                de_use_imm,
    input  logic [`XLEN-1:0]    de_pc,
    input  logic [`TAG_W-1:0]   de_tag,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic                ex_valid,
    output logic [4:0]          ex_rd,
    output logic [`XLEN-1:0]    ex_value,
    output logic [`XLEN-1:0]    ex_pc,
    output logic                jump_valid,
    output logic                jump_taken,
    output logic [`XLEN-1:0]    jump_target,
    output logic [`TAG_W-1:0]   jump_tag
);
    import core_pkg::*;

    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_res;
    logic               equal;
    logic               taken;

    assign rs1_addr = de_rs1;
    assign rs2_addr = de_rs2;

    assign op_b  = de_use_imm ? de_imm : rs2_data;
    assign equal = (rs1_data == rs2_data);

    always_comb begin
        case (de_alu_op)
            ALU_SUB:    alu_res = rs1_data - op_b;
            ALU_AND:    alu_res = rs1_data & op_b;
            ALU_OR:     alu_res = rs1_data | op_b;
            ALU_XOR:    alu_res = rs1_data ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (de_br_kind)
            BR_EQ:   taken = equal;
            BR_NE:   taken = !equal;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid   <= 1'b0;
            jump_valid <= 1'b0;
        end else begin
            ex_valid   <= de_valid;
            jump_valid <= de_valid && (de_br_kind != BR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (de_valid) begin
            ex_rd <= de_rd;
            ex_pc <= de_pc;
            // link value for JAL
            ex_value    <= (de_br_kind == BR_JAL) ? de_pc + 4 : alu_res;
            jump_taken  <= taken;
            jump_target <= de_pc + de_imm;
            jump_tag    <= de_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/result.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module result (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`XLEN-1:0]    rs1_data,
    output logic [`XLEN-1:0]    rs2_data,
    input  logic                ex_valid,
    input  logic [4:0]          ex_rd,
    input  logic [`XLEN-1:0]    ex_value,
    input  logic [`XLEN-1:0]    ex_pc,
    output logic                commit_valid,
    output logic [`XLEN-1:0]    commit_pc,
    output logic [4:0]          commit_rd,
    output logic [`XLEN-1:0]    commit_data
);

    logic [`XLEN-1:0] regs [1:31];

    // x0 reads zero and a same-cycle write is forwarded
    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (ex_valid && ex_rd == addr) begin
            return ex_value;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_rd != 5'd0) begin
            regs[ex_rd] <= ex_value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            commit_pc <= ex_pc;
            commit_rd <= ex_rd;
            // report what x0 actually holds
            commit_data <= (ex_rd == 5'd0) ? '0 : ex_value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_top (
    input  logic                clk,
    input  logic                rst,
    output logic                ireq_valid,
    output logic [`XLEN-1:0]    ireq_addr,
    input  logic                iresp_data_ok,
    input  logic [`XLEN-1:0]    iresp_data,
    output logic                commit_valid,
    output logic [`XLEN-1:0]    commit_pc,
    output logic [4:0]          commit_rd,
    output logic [`XLEN-1:0]    commit_data
);
    import core_pkg::*;

    logic               fd_valid;
    logic [`XLEN-1:0]   fd_inst;
    logic [`XLEN-1:0]   fd_pc;
    logic [`TAG_W-1:0]  fd_tag;

    logic               de_valid;
    alu_op_e            de_alu_op;
    br_kind_e           de_br_kind;
    logic [4:0]         de_rd;
    logic [4:0]         de_rs1;
    logic [4:0]         de_rs2;
    logic [`XLEN-1:0]   de_imm;
    logic               de_use_imm;
    logic [`XLEN-1:0]   de_pc;
    logic [`TAG_W-1:0]  de_tag;

    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;

    logic               ex_valid;
    logic [4:0]         ex_rd;
    logic [`XLEN-1:0]   ex_value;
    logic [`XLEN-1:0]   ex_pc;

    // branch and JAL resolution back to fetch
    logic               jump_valid;
    logic               jump_taken;
    logic [`XLEN-1:0]   jump_target;
    logic [`TAG_W-1:0]  jump_tag;

    fetch fetch_i (
        .clk           (clk),
        .rst           (rst),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .jump_valid    (jump_valid),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .jump_tag      (jump_tag),
        .fd_valid      (fd_valid),
        .fd_inst       (fd_inst),
        .fd_pc         (fd_pc),
        .fd_tag        (fd_tag)
    );

    decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .fd_valid   (fd_valid),
        .fd_inst    (fd_inst),
        .fd_pc      (fd_pc),
        .fd_tag     (fd_tag),
        .de_valid   (de_valid),
        .de_alu_op  (de_alu_op),
        .de_br_kind (de_br_kind),
        .de_rd      (de_rd),
        .de_rs1     (de_rs1),
        .de_rs2     (de_rs2),
        .de_imm     (de_imm),
        .de_use_imm (de_use_imm),
        .de_pc      (de_pc),
        .de_tag     (de_tag)
    );

    execute execute_i (
        .clk         (clk),
        .rst         (rst),
        .de_valid    (de_valid),
        .de_alu_op   (de_alu_op),
        .de_br_kind  (de_br_kind),
        .de_rd       (de_rd),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_imm      (de_imm),
        .de_use_imm  (de_use_imm),
        .de_pc       (de_pc),
        .de_tag      (de_tag),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_value    (ex_value),
        .ex_pc       (ex_pc),
        .jump_valid  (jump_valid),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .jump_tag    (jump_tag)
    );

    result result_i (
        .clk          (clk),
        .rst          (rst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_value     (ex_value),
        .ex_pc        (ex_pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

//--- tests/core_top_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_top_asserts (
    input  logic                clk,
    input  logic                rst,
    input  logic                ireq_valid,
    input  logic [`XLEN-1:0]    ireq_addr,
    input  logic                iresp_data_ok,
    input  logic [`XLEN-1:0]    iresp_data,
    input  logic                commit_valid,
    input  logic [`XLEN-1:0]    commit_pc,
    input  logic [4:0]          commit_rd
);
    import core_pkg::*;

    int          fail_count = 0;
    logic [63:0] branch_at;

    // which fetched words are branches, by word address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch_at <= '0;
        end else if (ireq_valid && iresp_data_ok) begin
            branch_at[ireq_addr[7:2]] <= (iresp_data[6:0] == BRANCH);
        end
    end

    addr_held: assert property (@(posedge clk) disable iff (rst)
        ireq_valid && !iresp_data_ok |=> ireq_valid && $stable(ireq_addr))
    else begin
        fail_count++;
        $error("instruction request dropped or moved before its response");
    end

    commit_spaced: assert property (@(posedge clk) disable iff (rst)
        commit_valid |=> !commit_valid)
    else begin
        fail_count++;
        $error("commits in two consecutive cycles");
    end

    branch_no_rd: assert property (@(posedge clk) disable iff (rst)
        commit_valid && branch_at[commit_pc[7:2]] |-> commit_rd == 5'd0)
    else begin
        fail_count++;
        $error("branch committed with a nonzero rd");
    end

endmodule

`default_nettype wire

//--- tests/core_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_top_tb;
    import core_pkg::*;

    localparam int          NUM_COMMITS = 40;
    localparam int          PROG_WORDS  = 32;
    localparam int          WAIT_LIMIT  = 60;
    localparam logic [31:0] SEED        = 32'h79918d68;

    logic               clk;
    logic               rst;
    logic               ireq_valid;
    logic [`XLEN-1:0]   ireq_addr;
    logic               iresp_data_ok;
    logic [`XLEN-1:0]   iresp_data;
    logic               commit_valid;
    logic [`XLEN-1:0]   commit_pc;
    logic [4:0]         commit_rd;
    logic [`XLEN-1:0]   commit_data;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] ref_pc;
    logic [31:0] ref_regs [32];
    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    bit          resp_seen;

    core_top core_top_i (
        .clk           (clk),
        .rst           (rst),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data)
    );

    bind core_top core_top_asserts asserts_i (
        .clk           (clk),
        .rst           (rst),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, LUI};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // ADDI to x0 with an immediate folded from the whole address
    function automatic logic [31:0] fill_inst(input logic [31:0] addr);
        return addi_inst(5'd0, 5'd0, addr[13:2] ^ addr[25:14] ^ {6'b0, addr[31:26]});
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < 32'(PROG_WORDS * 4)) begin
            return prog[addr[6:2]];
        end
        return fill_inst(addr);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one ISA step of the model, returns the commit the core should report
    function automatic void step_model(output logic [31:0] pc, output logic [4:0] rd,
                                       output logic [31:0] value);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        inst    = fetch_word(ref_pc);
        a       = ref_regs[inst[19:15]];
        b       = ref_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        pc      = ref_pc;
        rd      = inst[11:7];
        value   = 32'h0;
        next_pc = ref_pc + 32'd4;
        case (inst[6:0])
            OP_IMM: value = a + imm_i;
            OP: begin
                case ({inst[31:25], inst[14:12]})
                    {7'h00, 3'd0}: value = a + b;
                    {7'h20, 3'd0}: value = a - b;
                    {7'h00, 3'd4}: value = a ^ b;
                    {7'h00, 3'd6}: value = a | b;
                    {7'h00, 3'd7}: value = a & b;
                    default:       rd = 5'd0;
                endcase
            end
            LUI: value = {inst[31:12], 12'h0};
            BRANCH: begin
                rd = 5'd0;
                if (inst[12] ? (a != b) : (a == b)) begin
                    next_pc = ref_pc + imm_b;
                end
            end
            JAL: begin
                value   = ref_pc + 32'd4;
                next_pc = ref_pc + imm_j;
            end
            default: rd = 5'd0;
        endcase
        if (rd == 5'd0) begin
            value = 32'h0;
        end else begin
            ref_regs[rd] = value;
        end
        ref_pc = next_pc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = fill_inst(32'(i) << 2);
        end
        prog[0]  = addi_inst(5'd1, 5'd0, 12'd5);
        prog[1]  = addi_inst(5'd2, 5'd1, 12'hffd);
        prog[2]  = rtype_inst(7'h00, 3'd0, 5'd3, 5'd1, 5'd2);
        prog[3]  = rtype_inst(7'h20, 3'd0, 5'd4, 5'd2, 5'd1);
        prog[4]  = rtype_inst(7'h00, 3'd7, 5'd5, 5'd3, 5'd4);
        prog[5]  = rtype_inst(7'h00, 3'd6, 5'd6, 5'd5, 5'd2);
        prog[6]  = rtype_inst(7'h00, 3'd4, 5'd7, 5'd6, 5'd1);
        prog[7]  = lui_inst(5'd8, 20'habcde);
        prog[8]  = addi_inst(5'd8, 5'd8, 12'h123);
        // x0 write, then a read of x0
        prog[9]  = addi_inst(5'd0, 5'd0, 12'd77);
        prog[10] = rtype_inst(7'h00, 3'd0, 5'd9, 5'd0, 5'd1);
        prog[11] = branch_inst(3'd0, 5'd1, 5'd9, 13'd12);
        prog[12] = addi_inst(5'd10, 5'd0, 12'd1);
        prog[13] = addi_inst(5'd10, 5'd0, 12'd2);
        prog[14] = branch_inst(3'd1, 5'd1, 5'd9, 13'd8);
        prog[15] = branch_inst(3'd1, 5'd2, 5'd1, 13'd12);
        prog[16] = addi_inst(5'd11, 5'd0, 12'd3);
        prog[17] = addi_inst(5'd11, 5'd0, 12'd4);
        prog[18] = branch_inst(3'd0, 5'd2, 5'd3, 13'd8);
        prog[19] = jal_inst(5'd12, 21'd12);
        prog[20] = addi_inst(5'd13, 5'd0, 12'd9);
        prog[21] = addi_inst(5'd13, 5'd0, 12'd9);
        prog[22] = rtype_inst(7'h00, 3'd0, 5'd14, 5'd12, 5'd8);
        prog[23] = jal_inst(5'd15, 21'd8);
        prog[24] = addi_inst(5'd13, 5'd0, 12'd9);
        prog[25] = rtype_inst(7'h20, 3'd0, 5'd16, 5'd15, 5'd14);
    endtask

    // instruction memory, answers each request after 1 to 4 cycles
    initial begin : memory_model
        int          cnt;
        int          delay;
        logic [31:0] addr;
        bit          first;
        bit          done;
        iresp_data_ok = 1'b0;
        iresp_data    = '0;
        cnt = 0;
        while (rst !== 1'b0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        first = 1'b1;
        done  = 1'b0;
        while (!done) begin
            cnt = 0;
            while (!ireq_valid && cnt < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (!ireq_valid) begin
                $display("memory model: no instruction request for %0d cycles", WAIT_LIMIT);
                timeouts++;
                done = 1'b1;
            end else begin
                addr = ireq_addr;
                if (first) begin
                    check_value("first request address", `PC_INIT, addr);
                end
                first     = 1'b0;
                rng_state = lcg_next(rng_state);
                delay     = 1 + int'(rng_state[17:16]);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                iresp_data_ok = 1'b1;
                iresp_data    = fetch_word(addr);
                resp_seen     = 1'b1;
                @(posedge clk);
                #1;
                iresp_data_ok = 1'b0;
                check_value("request released after response", 32'd0, {31'd0, ireq_valid});
            end
        end
    end

    initial begin : commit_checker
        logic [31:0] exp_pc;
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        int          cnt;
        int          n;
        bit          stop;
        rst       = 1'b1;
        errors    = 0;
        timeouts  = 0;
        resp_seen = 1'b0;
        rng_state = SEED;
        load_program();
        ref_pc = `PC_INIT;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'h0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst  = 1'b0;
        n    = 0;
        stop = 1'b0;
        while (n < NUM_COMMITS && !stop) begin
            cnt = 0;
            while (!commit_valid && cnt < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (!commit_valid) begin
                $display("commit checker: no commit for %0d cycles after commit %0d",
                         WAIT_LIMIT, n);
                timeouts++;
                stop = 1'b1;
            end else begin
                if (!resp_seen) begin
                    $display("commit seen before any instruction response");
                    errors++;
                end
                step_model(exp_pc, exp_rd, exp_val);
                check_value($sformatf("commit %0d pc", n), exp_pc, commit_pc);
                check_value($sformatf("commit %0d rd", n), {27'd0, exp_rd}, {27'd0, commit_rd});
                check_value($sformatf("commit %0d data", n), exp_val, commit_data);
                n++;
                // step past this pulse
                @(posedge clk);
                #1;
            end
        end
        errors += core_top_i.asserts_i.fail_count;
        $display("commits checked: %0d, errors: %0d, timeouts: %0d", n, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_top.f
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/core_top.sv
tests/core_top_asserts.sv
tests/core_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module core_top_tb -f core_top.f -o core_top_sim

status=0
./obj_dir/core_top_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"
